// ==== axi_mem_pkg.sv ====
`default_nettype none

package axi_mem_pkg;

  localparam int ADDR_WIDTH = 16;
  localparam int DATA_WIDTH = 32;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int ID_BITS    = 4;
  localparam int LEN_BITS   = 8;
  localparam int SIZE_BITS  = 3;

  // sram geometry
  localparam int MEM_WORDS    = 1024;
  localparam int MEM_IDX_BITS = $clog2(MEM_WORDS);
  localparam int WORD_LSB     = $clog2(STRB_WIDTH);

  // aw payload as carried through the skid buffer
  localparam int AW_BITS = ID_BITS + ADDR_WIDTH + LEN_BITS + SIZE_BITS + 2;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [STRB_WIDTH-1:0] strb_t;
  typedef logic [ID_BITS-1:0]    id_t;
  typedef logic [LEN_BITS-1:0]   len_t;
  typedef logic [SIZE_BITS-1:0]  size_t;
  typedef logic [1:0]            burst_t;
  typedef logic [1:0]            resp_t;

  localparam burst_t BURST_FIXED = 2'b00;
  localparam burst_t BURST_INCR  = 2'b01;
  localparam burst_t BURST_WRAP  = 2'b10;

  localparam resp_t RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// ==== skid_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module skid_buffer #(
  parameter int WIDTH = 8
) (
  input  wire              clk_i,
  input  wire              rst_ni,
  input  wire              i_valid,
  output logic             o_ready,
  input  wire [WIDTH-1:0]  i_data,
  output logic             o_valid,
  input  wire              i_ready,
  output logic [WIDTH-1:0] o_data
);

  logic             s_valid;
  logic [WIDTH-1:0] s_data;
  logic             in_fire;
  logic             out_free;

  assign in_fire  = i_valid && o_ready;
  assign out_free = !o_valid || i_ready;

  // o_ready is low only while the spare entry is occupied
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      o_valid <= 1'b0;
      s_valid <= 1'b0;
      o_ready <= 1'b0;
    end else if (out_free) begin
      o_valid <= s_valid || in_fire;
      s_valid <= 1'b0;
      o_ready <= 1'b1;
    end else if (in_fire) begin
      s_valid <= 1'b1;
      o_ready <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (out_free) begin
      o_data <= s_valid ? s_data : i_data;
    end
    // downstream stalled while a word was already promised upstream
    if (in_fire && !out_free) begin
      s_data <= i_data;
    end
  end

  a_hold_out: assert property (@(posedge clk_i) disable iff (!rst_ni)
    o_valid && !i_ready |=> o_valid && $stable(o_data))
    else $error("skid output changed under back-pressure");

endmodule

`default_nettype wire

// ==== axi_addr.sv ====
`timescale 1ns/100ps
`default_nettype none

module axi_addr (
  input  wire axi_mem_pkg::addr_t  i_last_addr,
  input  wire axi_mem_pkg::size_t  i_size,
  input  wire axi_mem_pkg::burst_t i_burst,
  output axi_mem_pkg::addr_t       o_next_addr
);

  import axi_mem_pkg::*;

  addr_t step;
  addr_t aligned;

  // bytes per beat
  assign step = addr_t'(1) << i_size;

  // first beat may be unaligned, later beats start on the size boundary
  assign aligned = i_last_addr & ~(step - addr_t'(1));

  always_comb begin
    case (i_burst)
      BURST_FIXED: begin
        o_next_addr = i_last_addr;
      end
      // wrap boundary is not tracked here
      BURST_INCR, BURST_WRAP: begin
        o_next_addr = aligned + step;
      end
      default: begin
        o_next_addr = i_last_addr;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== axi_sram.sv ====
`timescale 1ns/100ps
`default_nettype none

module axi_sram (
  input  wire                     clk_i,
  input  wire                     i_we,
  input  wire axi_mem_pkg::addr_t i_waddr,
  input  wire axi_mem_pkg::data_t i_wdata,
  input  wire axi_mem_pkg::strb_t i_strb,
  input  wire                     i_re,
  input  wire axi_mem_pkg::addr_t i_raddr,
  output axi_mem_pkg::data_t      o_rdata
);

  import axi_mem_pkg::*;

  data_t                   mem [MEM_WORDS];
  logic [MEM_IDX_BITS-1:0] widx;
  logic [MEM_IDX_BITS-1:0] ridx;

  // byte address to word index, high bits dropped
  assign widx = i_waddr[WORD_LSB +: MEM_IDX_BITS];
  assign ridx = i_raddr[WORD_LSB +: MEM_IDX_BITS];

  always_ff @(posedge clk_i) begin
    if (i_we) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (i_strb[b]) begin
          mem[widx][8*b +: 8] <= i_wdata[8*b +: 8];
        end
      end
    end
  end

  // output holds between reads
  always_ff @(posedge clk_i) begin
    if (i_re) begin
      o_rdata <= mem[ridx];
    end
  end

endmodule

`default_nettype wire

// ==== axi_interface_slave.sv ====
`timescale 1ns/100ps
`default_nettype none

module axi_interface_slave (
  input  wire                      clk_i,
  input  wire                      rst_ni,
  // aw
  input  wire axi_mem_pkg::id_t    i_awid,
  input  wire axi_mem_pkg::addr_t  i_awaddr,
  input  wire axi_mem_pkg::len_t   i_awlen,
  input  wire axi_mem_pkg::size_t  i_awsize,
  input  wire axi_mem_pkg::burst_t i_awburst,
  input  wire                      i_awvalid,
  output logic                     o_awready,
  // w
  input  wire axi_mem_pkg::data_t  i_wdata,
  input  wire axi_mem_pkg::strb_t  i_wstrb,
  input  wire                      i_wvalid,
  input  wire                      i_wlast,
  output logic                     o_wready,
  // b
  output axi_mem_pkg::id_t         o_bid,
  output axi_mem_pkg::resp_t       o_bresp,
  output logic                     o_bvalid,
  input  wire                      i_bready,
  // ar
  input  wire axi_mem_pkg::id_t    i_arid,
  input  wire axi_mem_pkg::addr_t  i_araddr,
  input  wire axi_mem_pkg::len_t   i_arlen,
  input  wire axi_mem_pkg::burst_t i_arburst,
  input  wire axi_mem_pkg::size_t  i_arsize,
  input  wire                      i_arvalid,
  output logic                     o_arready,
  // r
  output axi_mem_pkg::id_t         o_rid,
  output axi_mem_pkg::data_t       o_rdata,
  output axi_mem_pkg::resp_t       o_rresp,
  output logic                     o_rvalid,
  output logic                     o_rlast,
  input  wire                      i_rready,
  // memory side
  output logic                     o_we,
  output axi_mem_pkg::addr_t       o_waddr,
  output axi_mem_pkg::data_t       o_wdata,
  output axi_mem_pkg::strb_t       o_strb,
  output logic                     o_re,
  output axi_mem_pkg::addr_t       o_raddr,
  input  wire axi_mem_pkg::data_t  i_rdata
);

  import axi_mem_pkg::*;

  logic   aw_valid;
  logic   aw_ready;
  id_t    aw_id;
  addr_t  aw_addr;
  len_t   aw_len;
  size_t  aw_size;
  burst_t aw_burst;

  addr_t  waddr;
  size_t  wsize;
  burst_t wburst;
  len_t   wcnt;
  id_t    wid;
  addr_t  next_waddr;
  logic   aw_fire;
  logic   w_fire;
  logic   w_end;

  logic   b_stall;
  logic   b_fire;
  logic   b_pend;
  id_t    b_pend_id;

  skid_buffer #(
    .WIDTH (AW_BITS)
  ) u_aw_skid (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .i_valid (i_awvalid),
    .o_ready (o_awready),
    .i_data  ({i_awid, i_awaddr, i_awlen, i_awsize, i_awburst}),
    .o_valid (aw_valid),
    .i_ready (aw_ready),
    .o_data  ({aw_id, aw_addr, aw_len, aw_size, aw_burst})
  );

  // next burst waits for the current one and for a free b slot
  assign aw_ready = !o_wready && !b_pend;
  assign aw_fire  = aw_valid && aw_ready;
  assign w_fire   = i_wvalid && o_wready;
  assign w_end    = w_fire && (wcnt == '0);
  assign b_stall  = o_bvalid && !i_bready;
  assign b_fire   = o_bvalid && i_bready;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      o_wready <= 1'b0;
    end else if (aw_fire) begin
      o_wready <= 1'b1;
    end else if (w_end) begin
      o_wready <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      waddr  <= aw_addr;
      wsize  <= aw_size;
      wburst <= aw_burst;
      wcnt   <= aw_len;
      wid    <= aw_id;
    end else if (w_fire) begin
      waddr <= next_waddr;
      wcnt  <= wcnt - len_t'(1);
    end
  end

  axi_addr u_wr_addr (
    .i_last_addr (waddr),
    .i_size      (wsize),
    .i_burst     (wburst),
    .o_next_addr (next_waddr)
  );

  assign o_we    = w_fire;
  assign o_waddr = waddr;
  assign o_wdata = i_wdata;
  assign o_strb  = i_wstrb;

  // second response parks here while bvalid is stuck
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      o_bvalid <= 1'b0;
      b_pend   <= 1'b0;
    end else if (w_end) begin
      if (b_stall) begin
        b_pend <= 1'b1;
      end else begin
        o_bvalid <= 1'b1;
      end
    end else if (b_fire) begin
      o_bvalid <= b_pend;
      b_pend   <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (w_end && b_stall) begin
      b_pend_id <= wid;
    end
    if (w_end && !b_stall) begin
      o_bid <= wid;
    end else if (b_fire) begin
      o_bid <= b_pend_id;
    end
  end

  assign o_bresp = RESP_OKAY;

  logic   r_busy;
  logic   r_issue;
  len_t   r_cnt;
  addr_t  raddr;
  size_t  rsize;
  burst_t rburst;
  addr_t  next_raddr;
  logic   ar_fire;
  logic   r_fire;

  // r_busy spans the whole burst, r_issue only until the last read strobe
  assign o_arready = !r_busy;
  assign ar_fire   = i_arvalid && o_arready;
  assign r_fire    = o_rvalid && i_rready;
  assign o_re      = r_issue && (!o_rvalid || i_rready);
  assign o_raddr   = raddr;
  assign o_rdata   = i_rdata;
  assign o_rresp   = RESP_OKAY;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      r_busy  <= 1'b0;
      r_issue <= 1'b0;
    end else if (ar_fire) begin
      r_busy  <= 1'b1;
      r_issue <= 1'b1;
    end else begin
      if (o_re && (r_cnt == '0)) begin
        r_issue <= 1'b0;
      end
      if (r_fire && o_rlast) begin
        r_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      raddr  <= i_araddr;
      rsize  <= i_arsize;
      rburst <= i_arburst;
      r_cnt  <= i_arlen;
      o_rid  <= i_arid;
    end else if (o_re) begin
      raddr <= next_raddr;
      r_cnt <= r_cnt - len_t'(1);
    end
  end

  axi_addr u_rd_addr (
    .i_last_addr (raddr),
    .i_size      (rsize),
    .i_burst     (rburst),
    .o_next_addr (next_raddr)
  );

  // beat shows up one cycle after its read strobe
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      o_rvalid <= 1'b0;
      o_rlast  <= 1'b0;
    end else if (o_re) begin
      o_rvalid <= 1'b1;
      o_rlast  <= (r_cnt == '0);
    end else if (r_fire) begin
      o_rvalid <= 1'b0;
      o_rlast  <= 1'b0;
    end
  end

  a_b_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    b_stall |=> o_bvalid && $stable(o_bid))
    else $error("bvalid dropped or bid changed before bready");

  // sram must keep its output while the beat is stalled
  a_r_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata) && $stable(o_rlast)
      && $stable(o_rid))
    else $error("r beat changed before rready");

  a_we_in_burst: assert property (@(posedge clk_i) disable iff (!rst_ni)
    o_we |-> o_wready && (i_wlast == (wcnt == '0)))
    else $error("write outside a burst or wlast off the beat count");

endmodule

`default_nettype wire

// ==== axi_mem_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module axi_mem_top (
  input  wire                      clk_i,
  input  wire                      rst_ni,
  input  wire axi_mem_pkg::id_t    i_awid,
  input  wire axi_mem_pkg::addr_t  i_awaddr,
  input  wire axi_mem_pkg::len_t   i_awlen,
  input  wire axi_mem_pkg::size_t  i_awsize,
  input  wire axi_mem_pkg::burst_t i_awburst,
  input  wire                      i_awvalid,
  output logic                     o_awready,
  input  wire axi_mem_pkg::data_t  i_wdata,
  input  wire axi_mem_pkg::strb_t  i_wstrb,
  input  wire                      i_wvalid,
  input  wire                      i_wlast,
  output logic                     o_wready,
  output axi_mem_pkg::id_t         o_bid,
  output axi_mem_pkg::resp_t       o_bresp,
  output logic                     o_bvalid,
  input  wire                      i_bready,
  input  wire axi_mem_pkg::id_t    i_arid,
  input  wire axi_mem_pkg::addr_t  i_araddr,
  input  wire axi_mem_pkg::len_t   i_arlen,
  input  wire axi_mem_pkg::burst_t i_arburst,
  input  wire axi_mem_pkg::size_t  i_arsize,
  input  wire                      i_arvalid,
  output logic                     o_arready,
  output axi_mem_pkg::id_t         o_rid,
  output axi_mem_pkg::data_t       o_rdata,
  output axi_mem_pkg::resp_t       o_rresp,
  output logic                     o_rvalid,
  output logic                     o_rlast,
  input  wire                      i_rready
);

  import axi_mem_pkg::*;

  // slave to sram strobes
  logic  mem_we;
  addr_t mem_waddr;
  data_t mem_wdata;
  strb_t mem_strb;
  logic  mem_re;
  addr_t mem_raddr;
  data_t mem_rdata;

  axi_interface_slave u_slave (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .i_awid    (i_awid),
    .i_awaddr  (i_awaddr),
    .i_awlen   (i_awlen),
    .i_awsize  (i_awsize),
    .i_awburst (i_awburst),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_wdata   (i_wdata),
    .i_wstrb   (i_wstrb),
    .i_wvalid  (i_wvalid),
    .i_wlast   (i_wlast),
    .o_wready  (o_wready),
    .o_bid     (o_bid),
    .o_bresp   (o_bresp),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .i_arid    (i_arid),
    .i_araddr  (i_araddr),
    .i_arlen   (i_arlen),
    .i_arburst (i_arburst),
    .i_arsize  (i_arsize),
    .i_arvalid (i_arvalid),
    .o_arready (o_arready),
    .o_rid     (o_rid),
    .o_rdata   (o_rdata),
    .o_rresp   (o_rresp),
    .o_rvalid  (o_rvalid),
    .o_rlast   (o_rlast),
    .i_rready  (i_rready),
    .o_we      (mem_we),
    .o_waddr   (mem_waddr),
    .o_wdata   (mem_wdata),
    .o_strb    (mem_strb),
    .o_re      (mem_re),
    .o_raddr   (mem_raddr),
    .i_rdata   (mem_rdata)
  );

  axi_sram u_sram (
    .clk_i   (clk_i),
    .i_we    (mem_we),
    .i_waddr (mem_waddr),
    .i_wdata (mem_wdata),
    .i_strb  (mem_strb),
    .i_re    (mem_re),
    .i_raddr (mem_raddr),
    .o_rdata (mem_rdata)
  );

endmodule

`default_nettype wire

// ==== tb_axi_mem_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_axi_mem_top;

  import axi_mem_pkg::*;

  localparam int MODEL_ABITS = MEM_IDX_BITS + WORD_LSB;

  logic   clk_i;
  logic   rst_ni;
  id_t    awid;
  addr_t  awaddr;
  len_t   awlen;
  size_t  awsize;
  burst_t awburst;
  logic   awvalid, awready;
  data_t  wdata;
  strb_t  wstrb;
  logic   wvalid, wlast, wready;
  id_t    bid;
  resp_t  bresp;
  logic   bvalid, bready;
  id_t    arid;
  addr_t  araddr;
  len_t   arlen;
  burst_t arburst;
  size_t  arsize;
  logic   arvalid, arready;
  id_t    rid;
  data_t  rdata;
  resp_t  rresp;
  logic   rvalid, rlast, rready;

  // byte image of what the sram should hold
  logic [7:0]  model [2**MODEL_ABITS];
  logic [7:0]  cmd_q [$];
  // id addr len size burst for each command
  logic [31:0] hdr_q [$];
  // data and strobe per write beat
  logic [31:0] beat_q [$];
  data_t       exp_rdata [$];
  id_t         exp_rid [$];
  logic        exp_rlast [$];
  id_t         exp_bid [$];
  int          beat_idx;
  int          total_beats;
  int          n_writes;
  int          errors;
  int          r_seen;
  int          b_seen;
  int          cycles;
  int          limit;

  axi_mem_top dut (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .i_awid    (awid),
    .i_awaddr  (awaddr),
    .i_awlen   (awlen),
    .i_awsize  (awsize),
    .i_awburst (awburst),
    .i_awvalid (awvalid),
    .o_awready (awready),
    .i_wdata   (wdata),
    .i_wstrb   (wstrb),
    .i_wvalid  (wvalid),
    .i_wlast   (wlast),
    .o_wready  (wready),
    .o_bid     (bid),
    .o_bresp   (bresp),
    .o_bvalid  (bvalid),
    .i_bready  (bready),
    .i_arid    (arid),
    .i_araddr  (araddr),
    .i_arlen   (arlen),
    .i_arburst (arburst),
    .i_arsize  (arsize),
    .i_arvalid (arvalid),
    .o_arready (arready),
    .o_rid     (rid),
    .o_rdata   (rdata),
    .o_rresp   (rresp),
    .o_rvalid  (rvalid),
    .o_rlast   (rlast),
    .i_rready  (rready)
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("error %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  function automatic addr_t next_addr(input addr_t a, input size_t sz, input burst_t bt);
    addr_t step;
    step = addr_t'(1 << sz);
    if (bt == BURST_FIXED) begin
      return a;
    end
    return a - (a % step) + step;
  endfunction

  function automatic data_t model_word(input addr_t a);
    data_t                  w;
    logic [MODEL_ABITS-1:0] base;
    int                     b;
    base = a[MODEL_ABITS-1:0] & ~MODEL_ABITS'(STRB_WIDTH - 1);
    for (b = 0; b < STRB_WIDTH; b++) begin
      w[8*b +: 8] = model[base + MODEL_ABITS'(b)];
    end
    return w;
  endfunction

  task automatic apply_beat(input addr_t a, input data_t d, input strb_t s);
    logic [MODEL_ABITS-1:0] base;
    int                     b;
    base = a[MODEL_ABITS-1:0] & ~MODEL_ABITS'(STRB_WIDTH - 1);
    for (b = 0; b < STRB_WIDTH; b++) begin
      if (s[b]) begin
        model[base + MODEL_ABITS'(b)] = d[8*b +: 8];
      end
    end
  endtask

  task automatic load_stim();
    int               fd;
    int               code;
    int               i;
    logic [7:0]       ch;
    logic [31:0]      f [5];
    logic [31:0]      d;
    logic [31:0]      s;
    logic [8*256-1:0] rest;
    fd = $fopen("axi_mem_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open axi_mem_stim.txt");
      errors++;
      return;
    end
    while ($fscanf(fd, " %c", ch) == 1) begin
      if (ch == "#") begin
        code = $fgets(rest, fd);
      end else begin
        code = $fscanf(fd, "%h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
        cmd_q.push_back(ch);
        for (i = 0; i < 5; i++) begin
          hdr_q.push_back(f[i]);
        end
        total_beats += int'(f[2]) + 1;
        if (ch == "W") begin
          n_writes++;
          for (i = 0; i <= int'(f[2]); i++) begin
            code = $fscanf(fd, "%h %h", d, s);
            beat_q.push_back(d);
            beat_q.push_back(s);
          end
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic idle_gap();
    int n;
    n = int'($urandom % 3);
    repeat (n) @(negedge clk_i);
  endtask

  // ready is settled 1 ns after the falling edge, so the transfer is known
  task automatic wait_accept(input int chan);
    logic ok;
    ok = 1'b0;
    while (!ok) begin
      #1;
      case (chan)
        0: ok = awready;
        1: ok = wready;
        default: ok = arready;
      endcase
      @(negedge clk_i);
    end
  endtask

  task automatic send_aw(input int k);
    idle_gap();
    awid    = hdr_q[5*k][ID_BITS-1:0];
    awaddr  = hdr_q[5*k+1][ADDR_WIDTH-1:0];
    awlen   = hdr_q[5*k+2][LEN_BITS-1:0];
    awsize  = hdr_q[5*k+3][SIZE_BITS-1:0];
    awburst = hdr_q[5*k+4][1:0];
    awvalid = 1'b1;
    wait_accept(0);
    awvalid = 1'b0;
  endtask

  task automatic send_wbeats(input int k);
    addr_t a;
    int    n;
    int    i;
    a = hdr_q[5*k+1][ADDR_WIDTH-1:0];
    n = int'(hdr_q[5*k+2]) + 1;
    for (i = 0; i < n; i++) begin
      idle_gap();
      wdata    = beat_q[beat_idx];
      wstrb    = beat_q[beat_idx+1][STRB_WIDTH-1:0];
      beat_idx += 2;
      wlast    = (i == n - 1);
      wvalid   = 1'b1;
      apply_beat(a, wdata, wstrb);
      wait_accept(1);
      wvalid = 1'b0;
      a = next_addr(a, hdr_q[5*k+3][SIZE_BITS-1:0], hdr_q[5*k+4][1:0]);
    end
  endtask

  task automatic run_write(input int k);
    exp_bid.push_back(hdr_q[5*k][ID_BITS-1:0]);
    fork
      send_aw(k);
      send_wbeats(k);
    join
  endtask

  task automatic run_read(input int k);
    addr_t a;
    int    n;
    int    i;
    a = hdr_q[5*k+1][ADDR_WIDTH-1:0];
    n = int'(hdr_q[5*k+2]) + 1;
    for (i = 0; i < n; i++) begin
      exp_rdata.push_back(model_word(a));
      exp_rid.push_back(hdr_q[5*k][ID_BITS-1:0]);
      exp_rlast.push_back(i == n - 1);
      a = next_addr(a, hdr_q[5*k+3][SIZE_BITS-1:0], hdr_q[5*k+4][1:0]);
    end
    idle_gap();
    arid    = hdr_q[5*k][ID_BITS-1:0];
    araddr  = hdr_q[5*k+1][ADDR_WIDTH-1:0];
    arlen   = hdr_q[5*k+2][LEN_BITS-1:0];
    arsize  = hdr_q[5*k+3][SIZE_BITS-1:0];
    arburst = hdr_q[5*k+4][1:0];
    arvalid = 1'b1;
    wait_accept(2);
    arvalid = 1'b0;
    while (exp_rdata.size() != 0) @(negedge clk_i);
  endtask

  always @(negedge clk_i) begin
    bready = ($urandom % 2) != 0;
    #1;
    if (rst_ni && bvalid && bready) begin
      if (exp_bid.size() == 0) begin
        $display("B response at %0t with no write burst outstanding", $time);
        errors++;
      end else begin
        compare_value("bid", 32'(bid), 32'(exp_bid.pop_front()));
        compare_value("bresp", 32'(bresp), 32'(RESP_OKAY));
        b_seen++;
      end
    end
  end

  always @(negedge clk_i) begin
    rready = ($urandom % 4) != 0;
    #1;
    if (rst_ni && rvalid && rready) begin
      if (exp_rdata.size() == 0) begin
        $display("R beat at %0t with no read burst outstanding", $time);
        errors++;
      end else begin
        compare_value("rdata", rdata, exp_rdata.pop_front());
        compare_value("rid", 32'(rid), 32'(exp_rid.pop_front()));
        compare_value("rlast", 32'(rlast), 32'(exp_rlast.pop_front()));
        compare_value("rresp", 32'(rresp), 32'(RESP_OKAY));
        r_seen++;
      end
    end
  end

  initial begin
    int k;
    void'($urandom(60));
    clk_i    = 1'b0;
    rst_ni   = 1'b0;
    awid     = '0;
    awaddr   = '0;
    awlen    = '0;
    awsize   = '0;
    awburst  = '0;
    awvalid  = 1'b0;
    wdata    = '0;
    wstrb    = '0;
    wvalid   = 1'b0;
    wlast    = 1'b0;
    bready   = 1'b0;
    arid     = '0;
    araddr   = '0;
    arlen    = '0;
    arburst  = '0;
    arsize   = '0;
    arvalid  = 1'b0;
    rready   = 1'b0;
    beat_idx = 0;
    errors   = 0;
    cycles   = 0;
    limit    = 200;
    foreach (model[j]) begin
      model[j] = 8'h00;
    end
    load_stim();
    limit = 40 * total_beats + 200;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    for (k = 0; k < cmd_q.size(); k++) begin
      if (cmd_q[k] == "W") begin
        run_write(k);
      end else begin
        run_read(k);
      end
    end
    while (exp_bid.size() != 0) @(negedge clk_i);
    repeat (4) @(negedge clk_i);
    $display("errors: %0d, R beats checked: %0d, B responses checked: %0d",
             errors, r_seen, b_seen);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== axi_mem_stim.txt ====
# cmd id addr len size burst, all hex; len is beats minus one, burst 0 fixed 1 incr
# W lines continue with data and strobe for each beat, R lines end after burst
W 1 0010 0 2 1 12345678 f
R 2 0010 0 2 1
W 3 0100 7 2 1 a0a0a0a0 f a1a1a1a1 f a2a2a2a2 f a3a3a3a3 f a4a4a4a4 f a5a5a5a5 f a6a6a6a6 f a7a7a7a7 f
W 4 0100 7 2 1 000000b0 1 0000b100 2 00b20000 4 b3000000 8 0000b4b4 3 b5b50000 c 00b600b6 5 b700b700 a
R 5 0100 7 2 1
W 6 0200 3 2 0 11111111 f 22222222 f 33333333 f 44444444 f
R 7 0200 3 2 0
W 8 0300 1 2 1 c3c3c3c3 f c4c4c4c4 f
W 9 0300 3 1 1 0000beef 3 cafe0000 c 00001234 3 56780000 c
R a 0300 1 2 1
R b 0300 3 1 1
W c 0400 3 2 1 d0d0d0d0 f d1d1d1d1 f d2d2d2d2 f d3d3d3d3 f
W d 0410 0 2 1 d4d4d4d4 f
W e 0414 2 2 1 d5d5d5d5 f d6d6d6d6 f d7d7d7d7 f
R f 0400 7 2 1
W 1 0500 3 2 1 e0e0e0e0 f e1e1e1e1 f e2e2e2e2 f e3e3e3e3 f
W 2 0500 1 2 1 0000f0f0 3 f1f10000 c
W 3 0508 0 2 1 00f200f2 5
R 4 0500 3 2 1
R 5 0504 0 2 0
R 6 0502 1 2 1

// ==== filelist.f ====
axi_mem_pkg.sv
skid_buffer.sv
axi_addr.sv
axi_sram.sv
axi_interface_slave.sv
axi_mem_top.sv
tb_axi_mem_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_axi_mem_top
FILELIST  := filelist.f
FLAGS     := --binary --timing --assert --timescale 1ns/100ps
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q '>>> PASS' $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/100ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
